// ==== Bender.yml ====
package:
  name: opreq

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/opreq_pkg.sv
      - hdl/rr_arbiter.sv
      - hdl/operand_requester_fsm.sv
      - hdl/vfu_write_stage.sv
      - hdl/vrf_arbiter.sv
      - hdl/opreq_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/tb_opreq.sv

// ==== hdl/operand_requester_fsm.sv ====
//////////////////////////////////////////////////////////////////////
// Walks one vector register a word at a time and requests reads.
// Reads are limited by credits from the operand queue, which start at
// OPQ_DEPTH. With a hazard set, one word is read per written result.
// A zero-length command is accepted and issues nothing.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "opreq_macros.svh"

module operand_requester_fsm (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Command from the sequencer
  input  logic                   cmd_valid_i,
  output logic                   cmd_ready_o,
  input  opreq_pkg::vreg_t       cmd_vs_i,
  input  opreq_pkg::len_t        cmd_len_i,
  input  opreq_pkg::vinsn_mask_t cmd_hazard_i,
  // One returned credit per pulse
  input  logic                   credit_i,
  input  opreq_pkg::vinsn_mask_t vinsn_retire_i,
  input  opreq_pkg::vinsn_mask_t result_written_i,
  // VRF arbiter side
  output logic                   req_o,
  output opreq_pkg::vaddr_t      addr_o,
  input  logic                   gnt_i
);

  import opreq_pkg::*;

  localparam int unsigned CREDIT_W   = $clog2(`OPQ_DEPTH + 1);
  localparam int unsigned WORD_SEL_W = $clog2(`VREG_WORDS);

  typedef enum logic {
    IDLE,
    REQUESTING
  } state_e;

  state_e              state_d, state_q;
  vaddr_t              addr_d, addr_q;
  len_t                len_d, len_q;
  vinsn_mask_t         hazard_d, hazard_q;
  logic [CREDIT_W-1:0] credit_d, credit_q;
  logic                stall;
  logic                last_gnt;

  // Blocked while a hazard instruction wrote nothing last cycle
  assign stall = |(hazard_q & ~result_written_i);

  assign req_o  = (state_q == REQUESTING) && (credit_q != '0) && !stall;
  assign addr_o = addr_q;

  // The final grant frees the requester for the next command
  assign last_gnt    = gnt_i && (len_q == len_t'(1));
  assign cmd_ready_o = (state_q == IDLE) || last_gnt;

  always_comb begin
    state_d  = state_q;
    addr_d   = addr_q;
    len_d    = len_q;
    hazard_d = hazard_q & ~vinsn_retire_i;

    if (gnt_i) begin
      addr_d = addr_q + vaddr_t'(1);
      len_d  = len_q - len_t'(1);
      if (last_gnt) begin
        state_d = IDLE;
      end
    end

    if (cmd_valid_i && cmd_ready_o) begin
      // Register vs starts at word vs * VREG_WORDS
      addr_d   = vaddr_t'({cmd_vs_i, {WORD_SEL_W{1'b0}}});
      len_d    = cmd_len_i;
      hazard_d = cmd_hazard_i & ~vinsn_retire_i;
      state_d  = (cmd_len_i != '0) ? REQUESTING : IDLE;
    end
  end

  // One credit spent per read, one back per pulse
  assign credit_d = credit_q + CREDIT_W'(credit_i) - CREDIT_W'(gnt_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      addr_q   <= '0;
      len_q    <= '0;
      hazard_q <= '0;
      credit_q <= CREDIT_W'(`OPQ_DEPTH);
    end else begin
      state_q  <= state_d;
      addr_q   <= addr_d;
      len_q    <= len_d;
      hazard_q <= hazard_d;
      credit_q <= credit_d;
    end
  end

endmodule

// ==== hdl/opreq_macros.svh ====
//////////////////////////////////////////////////////////////////////
// Sizing for one lane of the operand requester.
// VADDR_W must equal log2(32 registers * VREG_WORDS), and BANK_SEL_W
// must equal log2(NR_BANKS). Lengths count whole 64-bit words.
//////////////////////////////////////////////////////////////////////

`ifndef OPREQ_MACROS_SVH
`define OPREQ_MACROS_SVH

// VRF banks per lane
`define NR_BANKS 4
`define BANK_SEL_W 2

// In-flight instruction IDs
`define NR_VINSN 4

// Operand queue slots, also the credits a requester starts with
`define OPQ_DEPTH 3

// Words of one vector register inside one lane
`define VREG_WORDS 8

`define ELEN 64
`define VADDR_W 8
`define LEN_W 5

`endif

// ==== hdl/opreq_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared vector types for the lane operand requester.
// All widths derive from the macros header.
//////////////////////////////////////////////////////////////////////

`include "opreq_macros.svh"

package opreq_pkg;

  // One data word and its byte enables
  typedef logic [`ELEN-1:0]   elen_t;
  typedef logic [`ELEN/8-1:0] strb_t;

  // Lane word address; low bits pick the bank
  typedef logic [`VADDR_W-1:0] vaddr_t;

  // Word address inside one bank
  typedef logic [`VADDR_W-`BANK_SEL_W-1:0] bank_addr_t;

  // Instruction ID and one bit per ID
  typedef logic [$clog2(`NR_VINSN)-1:0] vid_t;
  typedef logic [`NR_VINSN-1:0]         vinsn_mask_t;

  // Register number, sized so that vs * VREG_WORDS fits a vaddr_t
  typedef logic [`VADDR_W-$clog2(`VREG_WORDS)-1:0] vreg_t;

  typedef logic [`LEN_W-1:0] len_t;

endpackage

// ==== hdl/opreq_top.sv ====
//////////////////////////////////////////////////////////////////////
// Lane operand requester with two read queues and two write ports.
// q0 and the ALU have priority over q1 and the load unit.
// The VRF is external and must take every bank request at once.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "opreq_macros.svh"

module opreq_top (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // Queue 0, high priority
  input  logic                                     q0_cmd_valid_i,
  output logic                                     q0_cmd_ready_o,
  input  opreq_pkg::vreg_t                         q0_cmd_vs_i,
  input  opreq_pkg::len_t                          q0_cmd_len_i,
  input  opreq_pkg::vinsn_mask_t                   q0_cmd_hazard_i,
  input  logic                                     q0_credit_i,
  // Queue 1, low priority
  input  logic                                     q1_cmd_valid_i,
  output logic                                     q1_cmd_ready_o,
  input  opreq_pkg::vreg_t                         q1_cmd_vs_i,
  input  opreq_pkg::len_t                          q1_cmd_len_i,
  input  opreq_pkg::vinsn_mask_t                   q1_cmd_hazard_i,
  input  logic                                     q1_credit_i,
  input  opreq_pkg::vinsn_mask_t                   vinsn_retire_i,
  // ALU result
  input  logic                                     alu_req_i,
  input  opreq_pkg::vid_t                          alu_id_i,
  input  opreq_pkg::vaddr_t                        alu_addr_i,
  input  opreq_pkg::elen_t                         alu_wdata_i,
  input  opreq_pkg::strb_t                         alu_be_i,
  output logic                                     alu_gnt_o,
  // Load unit result
  input  logic                                     ldu_req_i,
  input  opreq_pkg::vid_t                          ldu_id_i,
  input  opreq_pkg::vaddr_t                        ldu_addr_i,
  input  opreq_pkg::elen_t                         ldu_wdata_i,
  input  opreq_pkg::strb_t                         ldu_be_i,
  output logic                                     ldu_gnt_o,
  output logic                                     ldu_final_gnt_o,
  // VRF banks
  output logic                   [`NR_BANKS-1:0]   vrf_req_o,
  output opreq_pkg::bank_addr_t  [`NR_BANKS-1:0]   vrf_addr_o,
  output logic                   [`NR_BANKS-1:0]   vrf_wen_o,
  output opreq_pkg::elen_t       [`NR_BANKS-1:0]   vrf_wdata_o,
  output opreq_pkg::strb_t       [`NR_BANKS-1:0]   vrf_be_o,
  output logic                   [`NR_BANKS-1:0]   vrf_tgt_o
);

  import opreq_pkg::*;

  vinsn_mask_t result_written;
  logic        q0_req;
  vaddr_t      q0_addr;
  logic        q0_gnt;
  logic        q1_req;
  vaddr_t      q1_addr;
  logic        q1_gnt;
  logic        buf_req;
  vaddr_t      buf_addr;
  elen_t       buf_wdata;
  strb_t       buf_be;
  logic        buf_gnt;

  operand_requester_fsm i_opreq_q0 (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .cmd_valid_i     (q0_cmd_valid_i),
    .cmd_ready_o     (q0_cmd_ready_o),
    .cmd_vs_i        (q0_cmd_vs_i),
    .cmd_len_i       (q0_cmd_len_i),
    .cmd_hazard_i    (q0_cmd_hazard_i),
    .credit_i        (q0_credit_i),
    .vinsn_retire_i  (vinsn_retire_i),
    .result_written_i(result_written),
    .req_o           (q0_req),
    .addr_o          (q0_addr),
    .gnt_i           (q0_gnt)
  );

  operand_requester_fsm i_opreq_q1 (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .cmd_valid_i     (q1_cmd_valid_i),
    .cmd_ready_o     (q1_cmd_ready_o),
    .cmd_vs_i        (q1_cmd_vs_i),
    .cmd_len_i       (q1_cmd_len_i),
    .cmd_hazard_i    (q1_cmd_hazard_i),
    .credit_i        (q1_credit_i),
    .vinsn_retire_i  (vinsn_retire_i),
    .result_written_i(result_written),
    .req_o           (q1_req),
    .addr_o          (q1_addr),
    .gnt_i           (q1_gnt)
  );

  vfu_write_stage i_vfu_write_stage (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .ldu_req_i       (ldu_req_i),
    .ldu_id_i        (ldu_id_i),
    .ldu_addr_i      (ldu_addr_i),
    .ldu_wdata_i     (ldu_wdata_i),
    .ldu_be_i        (ldu_be_i),
    .ldu_gnt_o       (ldu_gnt_o),
    .ldu_final_gnt_o (ldu_final_gnt_o),
    .buf_req_o       (buf_req),
    .buf_addr_o      (buf_addr),
    .buf_wdata_o     (buf_wdata),
    .buf_be_o        (buf_be),
    .buf_gnt_i       (buf_gnt),
    .alu_id_i        (alu_id_i),
    .alu_gnt_i       (alu_gnt_o),
    .result_written_o(result_written)
  );

  vrf_arbiter i_vrf_arbiter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .q0_req_i   (q0_req),
    .q0_addr_i  (q0_addr),
    .q0_gnt_o   (q0_gnt),
    .q1_req_i   (q1_req),
    .q1_addr_i  (q1_addr),
    .q1_gnt_o   (q1_gnt),
    .alu_req_i  (alu_req_i),
    .alu_addr_i (alu_addr_i),
    .alu_wdata_i(alu_wdata_i),
    .alu_be_i   (alu_be_i),
    .alu_gnt_o  (alu_gnt_o),
    .buf_req_i  (buf_req),
    .buf_addr_i (buf_addr),
    .buf_wdata_i(buf_wdata),
    .buf_be_i   (buf_be),
    .buf_gnt_o  (buf_gnt),
    .vrf_req_o  (vrf_req_o),
    .vrf_addr_o (vrf_addr_o),
    .vrf_wen_o  (vrf_wen_o),
    .vrf_wdata_o(vrf_wdata_o),
    .vrf_be_o   (vrf_be_o),
    .vrf_tgt_o  (vrf_tgt_o)
  );

endmodule

// ==== hdl/rr_arbiter.sv ====
//////////////////////////////////////////////////////////////////////
// Two-input round-robin arbiter.
// The turn flips only when active_i says the grant was used.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rr_arbiter (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic [1:0] req_i,
  output logic [1:0] gnt_o,
  input  logic       active_i
);

  // Low means input 0 is preferred
  logic turn_q;

  assign gnt_o[0] = req_i[0] && (!turn_q || !req_i[1]);
  assign gnt_o[1] = req_i[1] && (turn_q || !req_i[0]);

  // Prefer the other input after a used grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      turn_q <= 1'b0;
    end else if (active_i && |req_i) begin
      turn_q <= gnt_o[0];
    end
  end

endmodule

// ==== hdl/vfu_write_stage.sv ====
//////////////////////////////////////////////////////////////////////
// One-entry stream register for load results, the delayed final grant
// and the mask of instructions that wrote a result last cycle.
// The load unit may push a new word in the cycle the old one drains.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module vfu_write_stage (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Load unit result port
  input  logic                   ldu_req_i,
  input  opreq_pkg::vid_t        ldu_id_i,
  input  opreq_pkg::vaddr_t      ldu_addr_i,
  input  opreq_pkg::elen_t       ldu_wdata_i,
  input  opreq_pkg::strb_t       ldu_be_i,
  output logic                   ldu_gnt_o,
  output logic                   ldu_final_gnt_o,
  // Buffered load word towards the VRF arbiter
  output logic                   buf_req_o,
  output opreq_pkg::vaddr_t      buf_addr_o,
  output opreq_pkg::elen_t       buf_wdata_o,
  output opreq_pkg::strb_t       buf_be_o,
  input  logic                   buf_gnt_i,
  // ALU write grant
  input  opreq_pkg::vid_t        alu_id_i,
  input  logic                   alu_gnt_i,
  output opreq_pkg::vinsn_mask_t result_written_o
);

  import opreq_pkg::*;

  vid_t        id_q;
  vinsn_mask_t written_d;

  // Room when empty or when the held word leaves this cycle
  assign ldu_gnt_o = !buf_req_o || buf_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buf_req_o <= 1'b0;
    end else if (ldu_gnt_o) begin
      buf_req_o <= ldu_req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ldu_req_i && ldu_gnt_o) begin
      id_q        <= ldu_id_i;
      buf_addr_o  <= ldu_addr_i;
      buf_wdata_o <= ldu_wdata_i;
      buf_be_o    <= ldu_be_i;
    end
  end

  // Both write grants tagged by instruction ID
  always_comb begin
    written_d            = '0;
    written_d[alu_id_i] |= alu_gnt_i;
    written_d[id_q]     |= buf_gnt_i;
  end

  // Final grant follows the bank write by one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ldu_final_gnt_o  <= 1'b0;
      result_written_o <= '0;
    end else begin
      ldu_final_gnt_o  <= buf_gnt_i;
      result_written_o <= written_d;
    end
  end

endmodule

// ==== hdl/vrf_arbiter.sv ====
//////////////////////////////////////////////////////////////////////
// Per-bank VRF arbitration for two read queues and two write ports.
// The pair (q0, ALU) always masks the pair (q1, load buffer).
// Every bank request is acknowledged in the cycle it is driven.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "opreq_macros.svh"

module vrf_arbiter (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // Read requesters
  input  logic                                     q0_req_i,
  input  opreq_pkg::vaddr_t                        q0_addr_i,
  output logic                                     q0_gnt_o,
  input  logic                                     q1_req_i,
  input  opreq_pkg::vaddr_t                        q1_addr_i,
  output logic                                     q1_gnt_o,
  // ALU result
  input  logic                                     alu_req_i,
  input  opreq_pkg::vaddr_t                        alu_addr_i,
  input  opreq_pkg::elen_t                         alu_wdata_i,
  input  opreq_pkg::strb_t                         alu_be_i,
  output logic                                     alu_gnt_o,
  // Buffered load result
  input  logic                                     buf_req_i,
  input  opreq_pkg::vaddr_t                        buf_addr_i,
  input  opreq_pkg::elen_t                         buf_wdata_i,
  input  opreq_pkg::strb_t                         buf_be_i,
  output logic                                     buf_gnt_o,
  // Banks
  output logic                   [`NR_BANKS-1:0]   vrf_req_o,
  output opreq_pkg::bank_addr_t  [`NR_BANKS-1:0]   vrf_addr_o,
  output logic                   [`NR_BANKS-1:0]   vrf_wen_o,
  output opreq_pkg::elen_t       [`NR_BANKS-1:0]   vrf_wdata_o,
  output opreq_pkg::strb_t       [`NR_BANKS-1:0]   vrf_be_o,
  output logic                   [`NR_BANKS-1:0]   vrf_tgt_o
);

  import opreq_pkg::*;

  // Grants seen by each requester, one bit per bank
  logic [`NR_BANKS-1:0] q0_gnt;
  logic [`NR_BANKS-1:0] q1_gnt;
  logic [`NR_BANKS-1:0] alu_gnt;
  logic [`NR_BANKS-1:0] buf_gnt;

  //////////////////////////////////////////////////////////////////////
  // Bank arbitration
  //////////////////////////////////////////////////////////////////////

  for (genvar b = 0; b < `NR_BANKS; b++) begin : gen_bank
    logic [1:0] hp_req;
    logic [1:0] hp_gnt;
    logic [1:0] lp_req;
    logic [1:0] lp_gnt;
    logic [1:0] lp_gnt_m;
    logic       hp_any;
    bank_addr_t addr_mux;
    logic       wen_mux;
    elen_t      wdata_mux;
    strb_t      be_mux;
    logic       tgt_mux;

    // Bank is picked by the low address bits
    assign hp_req[0] = q0_req_i && (q0_addr_i[`BANK_SEL_W-1:0] == `BANK_SEL_W'(b));
    assign hp_req[1] = alu_req_i && (alu_addr_i[`BANK_SEL_W-1:0] == `BANK_SEL_W'(b));
    assign lp_req[0] = q1_req_i && (q1_addr_i[`BANK_SEL_W-1:0] == `BANK_SEL_W'(b));
    assign lp_req[1] = buf_req_i && (buf_addr_i[`BANK_SEL_W-1:0] == `BANK_SEL_W'(b));

    assign hp_any = |hp_req;

    rr_arbiter i_hp_arbiter (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (hp_req),
      .gnt_o   (hp_gnt),
      .active_i(1'b1)
    );

    // Low pair keeps its turn while masked
    rr_arbiter i_lp_arbiter (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (lp_req),
      .gnt_o   (lp_gnt),
      .active_i(!hp_any)
    );

    assign lp_gnt_m = lp_gnt & {2{!hp_any}};

    assign q0_gnt[b]  = hp_gnt[0];
    assign alu_gnt[b] = hp_gnt[1];
    assign q1_gnt[b]  = lp_gnt_m[0];
    assign buf_gnt[b] = lp_gnt_m[1];

    // Winner payload; reads carry no data
    always_comb begin
      addr_mux  = '0;
      wen_mux   = 1'b0;
      wdata_mux = '0;
      be_mux    = '0;
      tgt_mux   = 1'b0;
      if (hp_gnt[0]) begin
        addr_mux = q0_addr_i[`VADDR_W-1:`BANK_SEL_W];
      end else if (hp_gnt[1]) begin
        addr_mux  = alu_addr_i[`VADDR_W-1:`BANK_SEL_W];
        wen_mux   = 1'b1;
        wdata_mux = alu_wdata_i;
        be_mux    = alu_be_i;
      end else if (lp_gnt_m[0]) begin
        addr_mux = q1_addr_i[`VADDR_W-1:`BANK_SEL_W];
        tgt_mux  = 1'b1;
      end else if (lp_gnt_m[1]) begin
        addr_mux  = buf_addr_i[`VADDR_W-1:`BANK_SEL_W];
        wen_mux   = 1'b1;
        wdata_mux = buf_wdata_i;
        be_mux    = buf_be_i;
      end
    end

    assign vrf_req_o[b]   = hp_any || (|lp_req);
    assign vrf_addr_o[b]  = addr_mux;
    assign vrf_wen_o[b]   = wen_mux;
    assign vrf_wdata_o[b] = wdata_mux;
    assign vrf_be_o[b]    = be_mux;
    assign vrf_tgt_o[b]   = tgt_mux;
  end

  //////////////////////////////////////////////////////////////////////
  // Grant collection
  //////////////////////////////////////////////////////////////////////

  assign q0_gnt_o  = |q0_gnt;
  assign q1_gnt_o  = |q1_gnt;
  assign alu_gnt_o = |alu_gnt;
  assign buf_gnt_o = |buf_gnt;

endmodule

// ==== sim.f ====
+incdir+hdl
hdl/opreq_pkg.sv
hdl/rr_arbiter.sv
hdl/operand_requester_fsm.sv
hdl/vfu_write_stage.sv
hdl/vrf_arbiter.sv
hdl/opreq_top.sv
test/tb_opreq.sv

// ==== test/tb_opreq.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the lane operand requester.
// The VRF is modeled by a monitor that takes every bank request.
// q0's request is read from inside the top level for the priority check.
// ALU writes and load writes each reach the banks in their issue order.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "opreq_macros.svh"

module tb_opreq;

  import opreq_pkg::*;

  localparam int unsigned NUM_TESTS   = 6;
  localparam int unsigned CYCLE_LIMIT = 40 * NUM_TESTS;

  typedef struct packed {
    logic [`BANK_SEL_W-1:0] bank;
    bank_addr_t             addr;
    elen_t                  data;
    strb_t                  be;
  } wr_rec_t;

  logic                             clk_i;
  logic                             rst_ni;
  logic                             q0_cmd_valid_i;
  logic                             q0_cmd_ready_o;
  vreg_t                            q0_cmd_vs_i;
  len_t                             q0_cmd_len_i;
  vinsn_mask_t                      q0_cmd_hazard_i;
  logic                             q0_credit_i;
  logic                             q1_cmd_valid_i;
  logic                             q1_cmd_ready_o;
  vreg_t                            q1_cmd_vs_i;
  len_t                             q1_cmd_len_i;
  vinsn_mask_t                      q1_cmd_hazard_i;
  logic                             q1_credit_i;
  vinsn_mask_t                      vinsn_retire_i;
  logic                             alu_req_i;
  vid_t                             alu_id_i;
  vaddr_t                           alu_addr_i;
  elen_t                            alu_wdata_i;
  strb_t                            alu_be_i;
  logic                             alu_gnt_o;
  logic                             ldu_req_i;
  vid_t                             ldu_id_i;
  vaddr_t                           ldu_addr_i;
  elen_t                            ldu_wdata_i;
  strb_t                            ldu_be_i;
  logic                             ldu_gnt_o;
  logic                             ldu_final_gnt_o;
  logic       [`NR_BANKS-1:0]       vrf_req_o;
  bank_addr_t [`NR_BANKS-1:0]       vrf_addr_o;
  logic       [`NR_BANKS-1:0]       vrf_wen_o;
  elen_t      [`NR_BANKS-1:0]       vrf_wdata_o;
  strb_t      [`NR_BANKS-1:0]       vrf_be_o;
  logic       [`NR_BANKS-1:0]       vrf_tgt_o;

  // Scoreboard
  vaddr_t      exp_q0[$];
  vaddr_t      exp_q1[$];
  wr_rec_t     exp_wr[$];
  wr_rec_t     exp_ld[$];
  string       test_name;
  int unsigned cycle_cnt;
  int unsigned mismatch_cnt;
  int unsigned error_cnt;
  int unsigned q0_reads;
  int unsigned q1_reads;
  int unsigned final_cnt;
  int unsigned owed[2];
  logic        credit_on[2];
  logic        hz_active;
  vid_t        hz_id;
  int unsigned hz_reads;
  int unsigned hz_writes;
  logic        load_wr_last;

  opreq_top i_opreq_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Word i of register vs sits at lane address vs * VREG_WORDS + i.
  // Its bank is the low address bits, the bank word the upper bits
  function automatic vaddr_t expected_read(input vreg_t vs, input int unsigned i);
    int unsigned word;
    word = vs * `VREG_WORDS + i;
    return vaddr_t'(word);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // VRF traffic monitor and comparison
  //////////////////////////////////////////////////////////////////////

  task automatic check_read(input int q, input int b);
    vaddr_t exp;
    vaddr_t act;
    logic   found;
    act   = {vrf_addr_o[b], `BANK_SEL_W'(b)};
    found = 1'b0;
    if (q == 0) begin
      q0_reads++;
      if (exp_q0.size() > 0) begin
        exp   = exp_q0.pop_front();
        found = 1'b1;
      end
    end else begin
      q1_reads++;
      if (hz_active) hz_reads++;
      if (exp_q1.size() > 0) begin
        exp   = exp_q1.pop_front();
        found = 1'b1;
      end
    end
    if (!found) begin
      error_cnt++;
      $display("Unexpected q%0d read of bank %0d word %0d in %s", q, b, vrf_addr_o[b],
               test_name);
    end else if (exp !== act) begin
      mismatch_cnt++;
      $display("Mismatch in %s: q%0d read expected bank %0d word %0d, actual bank %0d word %0d",
               test_name, q, exp[`BANK_SEL_W-1:0], exp[`VADDR_W-1:`BANK_SEL_W], b,
               vrf_addr_o[b]);
    end
  endtask

  task automatic check_write(input int b, input logic is_load);
    wr_rec_t exp;
    wr_rec_t act;
    logic    found;
    act.bank = `BANK_SEL_W'(b);
    act.addr = vrf_addr_o[b];
    act.data = vrf_wdata_o[b];
    act.be   = vrf_be_o[b];
    found    = 1'b0;
    if (is_load) begin
      if (exp_ld.size() > 0) begin
        exp   = exp_ld.pop_front();
        found = 1'b1;
      end
    end else if (exp_wr.size() > 0) begin
      exp   = exp_wr.pop_front();
      found = 1'b1;
    end
    if (!found) begin
      error_cnt++;
      $display("Unexpected %s write on bank %0d in %s", is_load ? "load" : "ALU", b,
               test_name);
    end else if (exp !== act) begin
      mismatch_cnt++;
      $display("Mismatch in %s: write expected %h, actual %h", test_name, exp, act);
    end
  endtask

  always @(posedge clk_i) begin : monitor
    logic hp_b;
    logic alu_b;
    logic load_wr_now;
    cycle_cnt++;
    load_wr_now = 1'b0;
    if (rst_ni) begin
      for (int b = 0; b < `NR_BANKS; b++) begin
        alu_b = alu_req_i && (alu_addr_i[`BANK_SEL_W-1:0] == `BANK_SEL_W'(b));
        hp_b  = alu_b || (i_opreq_top.q0_req &&
                (i_opreq_top.q0_addr[`BANK_SEL_W-1:0] == `BANK_SEL_W'(b)));
        alu_b = alu_b && alu_gnt_o;
        if (vrf_req_o[b]) begin
          if (vrf_wen_o[b]) begin
            if (!alu_b) begin
              load_wr_now = 1'b1;
              if (hp_b) begin
                error_cnt++;
                $display("Load write on bank %0d while q0 or the ALU requested it in %s",
                         b, test_name);
              end
            end
            check_write(b, !alu_b);
          end else if (vrf_tgt_o[b]) begin
            if (hp_b) begin
              error_cnt++;
              $display("q1 read on bank %0d while q0 or the ALU requested it in %s",
                       b, test_name);
            end
            check_read(1, b);
            owed[1]++;
          end else begin
            check_read(0, b);
            owed[0]++;
          end
        end
      end

      // Each hazard read needs a write of that ID in an earlier cycle
      if (hz_active) begin
        if (hz_reads > hz_writes) begin
          error_cnt++;
          $display("q1 read %0d words after only %0d writes of its hazard ID in %s",
                   hz_reads, hz_writes, test_name);
        end
        if (alu_req_i && alu_gnt_o && alu_id_i == hz_id) hz_writes++;
      end

      if (ldu_final_gnt_o && !load_wr_last) begin
        error_cnt++;
        $display("Final load grant without a load write one cycle before in %s", test_name);
      end else if (!ldu_final_gnt_o && load_wr_last) begin
        error_cnt++;
        $display("No final load grant one cycle after the load write in %s", test_name);
      end
      if (ldu_final_gnt_o) final_cnt++;
    end
    load_wr_last = load_wr_now;
  end

  // Operand queues hand back one credit per read, with random gaps
  always @(negedge clk_i) begin
    q0_credit_i = 1'b0;
    q1_credit_i = 1'b0;
    if (credit_on[0] && owed[0] > 0 && ($urandom % 4) != 0) begin
      q0_credit_i = 1'b1;
      owed[0]--;
    end
    if (credit_on[1] && owed[1] > 0 && ($urandom % 4) != 0) begin
      q1_credit_i = 1'b1;
      owed[1]--;
    end
  end

  initial begin : watchdog
    wait (cycle_cnt >= CYCLE_LIMIT);
    $display("Timeout after %0d cycles in %s", cycle_cnt, test_name);
    $display("Errors found");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks, all called on a falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic start_test(input string name);
    test_name = name;
    q0_reads  = 0;
    q1_reads  = 0;
    final_cnt = 0;
    hz_reads  = 0;
    hz_writes = 0;
  endtask

  task automatic issue_cmd(input int q, input vreg_t vs, input len_t len,
                           input vinsn_mask_t hz);
    for (int unsigned i = 0; i < len; i++) begin
      if (q == 0) exp_q0.push_back(expected_read(vs, i));
      else exp_q1.push_back(expected_read(vs, i));
    end
    if (q == 0) begin
      q0_cmd_valid_i  = 1'b1;
      q0_cmd_vs_i     = vs;
      q0_cmd_len_i    = len;
      q0_cmd_hazard_i = hz;
    end else begin
      q1_cmd_valid_i  = 1'b1;
      q1_cmd_vs_i     = vs;
      q1_cmd_len_i    = len;
      q1_cmd_hazard_i = hz;
    end
    do @(posedge clk_i); while (q == 0 ? !q0_cmd_ready_o : !q1_cmd_ready_o);
    @(negedge clk_i);
    if (q == 0) q0_cmd_valid_i = 1'b0;
    else q1_cmd_valid_i = 1'b0;
  endtask

  task automatic alu_write(input vid_t id, input vaddr_t addr);
    wr_rec_t rec;
    rec.bank = addr[`BANK_SEL_W-1:0];
    rec.addr = addr[`VADDR_W-1:`BANK_SEL_W];
    rec.data = {$urandom, $urandom};
    rec.be   = strb_t'($urandom);
    exp_wr.push_back(rec);
    alu_req_i   = 1'b1;
    alu_id_i    = id;
    alu_addr_i  = addr;
    alu_wdata_i = rec.data;
    alu_be_i    = rec.be;
    do @(posedge clk_i); while (!alu_gnt_o);
    @(negedge clk_i);
    alu_req_i = 1'b0;
  endtask

  task automatic ldu_write(input vid_t id, input vaddr_t addr);
    wr_rec_t rec;
    rec.bank = addr[`BANK_SEL_W-1:0];
    rec.addr = addr[`VADDR_W-1:`BANK_SEL_W];
    rec.data = {$urandom, $urandom};
    rec.be   = strb_t'($urandom);
    exp_ld.push_back(rec);
    ldu_req_i   = 1'b1;
    ldu_id_i    = id;
    ldu_addr_i  = addr;
    ldu_wdata_i = rec.data;
    ldu_be_i    = rec.be;
    do @(posedge clk_i); while (!ldu_gnt_o);
    @(negedge clk_i);
    ldu_req_i = 1'b0;
  endtask

  // Done when every expected word arrived and both queues are free
  task automatic wait_idle();
    while (exp_q0.size() > 0 || exp_q1.size() > 0 || exp_wr.size() > 0 ||
           exp_ld.size() > 0 || !q0_cmd_ready_o || !q1_cmd_ready_o) begin
      @(negedge clk_i);
    end
  endtask

  task automatic check_count(input string what, input int unsigned exp,
                             input int unsigned act);
    if (exp != act) begin
      mismatch_cnt++;
      $display("Mismatch in %s: %s expected %0d, actual %0d", test_name, what, exp, act);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    vreg_t vs0;
    len_t  len0;
    len_t  len1;
    vid_t  id;
    void'($urandom(22));
    rst_ni          = 1'b0;
    q0_cmd_valid_i  = 1'b0;
    q0_cmd_vs_i     = '0;
    q0_cmd_len_i    = '0;
    q0_cmd_hazard_i = '0;
    q0_credit_i     = 1'b0;
    q1_cmd_valid_i  = 1'b0;
    q1_cmd_vs_i     = '0;
    q1_cmd_len_i    = '0;
    q1_cmd_hazard_i = '0;
    q1_credit_i     = 1'b0;
    vinsn_retire_i  = '0;
    alu_req_i       = 1'b0;
    alu_id_i        = '0;
    alu_addr_i      = '0;
    alu_wdata_i     = '0;
    alu_be_i        = '0;
    ldu_req_i       = 1'b0;
    ldu_id_i        = '0;
    ldu_addr_i      = '0;
    ldu_wdata_i     = '0;
    ldu_be_i        = '0;
    cycle_cnt       = 0;
    mismatch_cnt    = 0;
    error_cnt       = 0;
    owed[0]         = 0;
    owed[1]         = 0;
    credit_on[0]    = 1'b1;
    credit_on[1]    = 1'b1;
    hz_active       = 1'b0;
    hz_id           = '0;
    load_wr_last    = 1'b0;
    start_test("reset");

    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    if (q0_cmd_ready_o !== 1'b1 || q1_cmd_ready_o !== 1'b1 || vrf_req_o !== '0 ||
        ldu_final_gnt_o !== 1'b0 || i_opreq_top.result_written !== '0) begin
      error_cnt++;
      $display("Outputs do not hold their idle values after reset");
    end

    start_test("read_walk");
    len0 = len_t'(1 + $urandom % `VREG_WORDS);
    issue_cmd(0, vreg_t'($urandom), len0, '0);
    wait_idle();
    check_count("q0 read count", len0, q0_reads);

    // q1 gets no credits back until it has spent them all
    start_test("credits");
    credit_on[1] = 1'b0;
    len1 = len_t'(`VREG_WORDS);
    issue_cmd(1, vreg_t'($urandom), len1, '0);
    while (q1_reads < `OPQ_DEPTH) @(negedge clk_i);
    repeat (2 * `OPQ_DEPTH) @(negedge clk_i);
    check_count("q1 reads without credits", `OPQ_DEPTH, q1_reads);
    credit_on[1] = 1'b1;
    wait_idle();
    check_count("q1 read count", len1, q1_reads);

    start_test("writes");
    alu_write(vid_t'($urandom), vaddr_t'($urandom));
    ldu_write(vid_t'($urandom), vaddr_t'($urandom));
    wait_idle();
    repeat (2) @(negedge clk_i);
    check_count("final load grants", 1, final_cnt);

    // Same bank pattern for both queues, so q1 keeps meeting q0
    start_test("priority");
    vs0  = vreg_t'($urandom);
    len0 = len_t'(1 + $urandom % `VREG_WORDS);
    len1 = len_t'(1 + $urandom % `VREG_WORDS);
    fork
      issue_cmd(0, vs0, len0, '0);
      issue_cmd(1, vs0 + vreg_t'(1), len1, '0);
      repeat (4) begin
        repeat ($urandom % 3) @(negedge clk_i);
        alu_write(vid_t'($urandom), vaddr_t'($urandom));
      end
      // Loads go to bank 0, where both queues read first
      repeat (2) begin
        ldu_write(vid_t'($urandom), vaddr_t'($urandom) & ~vaddr_t'(`NR_BANKS - 1));
      end
    join
    wait_idle();
    check_count("q0 read count", len0, q0_reads);
    check_count("q1 read count", len1, q1_reads);

    start_test("hazard");
    id        = vid_t'($urandom);
    hz_id     = id;
    hz_active = 1'b1;
    len1      = len_t'(4);
    issue_cmd(1, vreg_t'($urandom), len1, vinsn_mask_t'(1) << id);
    repeat (2) alu_write(id, vaddr_t'($urandom));
    repeat (4) @(negedge clk_i);
    hz_active      = 1'b0;
    vinsn_retire_i = vinsn_mask_t'(1) << id;
    @(negedge clk_i);
    vinsn_retire_i = '0;
    wait_idle();
    check_count("q1 read count", len1, q1_reads);

    start_test("zero_length");
    issue_cmd(0, vreg_t'($urandom), '0, '0);
    repeat (4) begin
      @(posedge clk_i);
      if (q0_cmd_ready_o !== 1'b1) begin
        error_cnt++;
        $display("q0 dropped cmd_ready after a zero-length command");
      end
    end
    @(negedge clk_i);
    check_count("q0 read count", 0, q0_reads);

    $display("Summary: %0d mismatches, %0d other failures", mismatch_cnt, error_cnt);
    if (mismatch_cnt + error_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
